// ==== Makefile ====
# Verilator build and run of the merge sorter testbench

VERILATOR ?= verilator
TOP       ?= msort_tb
SEED      ?= 32'hdf3f1908
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f

VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: VERILATOR TOP SEED LOG BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) \
		-GSEED="$(SEED)" -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
rtl/msort_pkg.sv
rtl/row_fifo.sv
rtl/pair_sort.sv
rtl/run_merge.sv
rtl/sort_collect.sv
rtl/msort_top.sv
test/msort_checker.sv
test/msort_tb.sv

// ==== rtl/msort_pkg.sv ====
package msort_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // table geometry
    ////////////////////////////////////////////////////////////////////////////

    // one element of the table, one byte
    localparam int ELEM_W    = 8;
    // elements per row
    localparam int COLUMNS   = 3;
    // rows per frame, must be 2**LEVELS
    localparam int ROWS      = 8;
    localparam int LEVELS    = 3;
    localparam int ROW_IDX_W = 3;

    // one fifo per pair sorter or merger in the whole tree
    localparam int NODES     = ROWS - 1;

    typedef logic [ELEM_W-1:0] elem_t;

    // column 0 sits in the low byte
    typedef elem_t [COLUMNS-1:0] row_t;

    // row 0 sits in the low bits
    typedef row_t [ROWS-1:0] frame_t;

    // producer to fifo, row is only looked at when wr is high
    typedef struct packed {
        logic wr;
        row_t row;
    } link_t;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // key column chosen by sort_num
    function automatic elem_t row_key(row_t r, logic sel);
        return sel ? r[1] : r[0];
    endfunction

    // first fifo node of a level, levels are packed one after another
    function automatic int level_base(int lv);
        return ROWS - (ROWS >> lv);
    endfunction

    // sorters or mergers on a level
    function automatic int level_units(int lv);
        return ROWS >> (lv + 1);
    endfunction

endpackage

// ==== rtl/msort_top.sv ====
`timescale 1ns/1ps

module msort_top import msort_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  logic   sort_num,
    input  frame_t data_in,
    output frame_t data_out,
    output logic   sorted
);

    ////////////////////////////////////////////////////////////////////////////
    // fifo nodes
    ////////////////////////////////////////////////////////////////////////////

    // level 0 holds nodes 0..3, level 1 nodes 4..5, level 2 node 6
    link_t node_link  [NODES];
    logic  node_empty [NODES];
    row_t  node_head  [NODES];
    logic  node_rd    [NODES];

    ////////////////////////////////////////////////////////////////////////////
    // sort tree
    ////////////////////////////////////////////////////////////////////////////

    for (genvar lv = 0; lv < LEVELS; lv++) begin : g_level
        for (genvar j = 0; j < level_units(lv); j++) begin : g_unit

            if (lv == 0) begin : g_pair
                // adjacent input rows, even one on the a side
                pair_sort u_pair (
                    .clk      (clk),
                    .arst_n   (arst_n),
                    .start    (start),
                    .sort_num (sort_num),
                    .row_a    (data_in[2*j]),
                    .row_b    (data_in[2*j+1]),
                    .out_link (node_link[j])
                );
            end else begin : g_merge
                // even fifo below feeds left, odd one feeds right
                run_merge #(
                    .RUN_LEN (1 << lv)
                ) u_merge (
                    .clk         (clk),
                    .arst_n      (arst_n),
                    .sort_num    (sort_num),
                    .left_empty  (node_empty[level_base(lv-1) + 2*j]),
                    .left_head   (node_head[level_base(lv-1) + 2*j]),
                    .right_empty (node_empty[level_base(lv-1) + 2*j + 1]),
                    .right_head  (node_head[level_base(lv-1) + 2*j + 1]),
                    .left_rd     (node_rd[level_base(lv-1) + 2*j]),
                    .right_rd    (node_rd[level_base(lv-1) + 2*j + 1]),
                    .out_link    (node_link[level_base(lv) + j])
                );
            end

            // deep enough for the whole run written on this level
            row_fifo #(
                .DEPTH_LOG2 (lv + 1)
            ) u_fifo (
                .clk     (clk),
                .arst_n  (arst_n),
                .wr_link (node_link[level_base(lv) + j]),
                .rd      (node_rd[level_base(lv) + j]),
                .empty   (node_empty[level_base(lv) + j]),
                .head    (node_head[level_base(lv) + j])
            );
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output
    ////////////////////////////////////////////////////////////////////////////

    // last node holds the fully merged frame
    sort_collect u_collect (
        .clk        (clk),
        .arst_n     (arst_n),
        .fifo_empty (node_empty[NODES-1]),
        .fifo_head  (node_head[NODES-1]),
        .fifo_rd    (node_rd[NODES-1]),
        .data_out   (data_out),
        .sorted     (sorted)
    );

endmodule

// ==== rtl/pair_sort.sv ====
`timescale 1ns/1ps

module pair_sort import msort_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  logic  sort_num,
    input  row_t  row_a,
    input  row_t  row_b,
    output link_t out_link
);

    logic swap;
    row_t lo_row;
    row_t hi_row;

    // second row still to be written
    logic pend_q;
    logic wr_q;
    row_t row_q;
    row_t held_q;

    // swap only on a strictly smaller right key, ties keep input order
    always_comb begin
        swap   = row_key(row_b, sort_num) < row_key(row_a, sort_num);
        lo_row = swap ? row_b : row_a;
        hi_row = swap ? row_a : row_b;
    end

    // write strobe, lower row then the other one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q   <= 1'b0;
            pend_q <= 1'b0;
        end else if (start) begin
            wr_q   <= 1'b1;
            pend_q <= 1'b1;
        end else begin
            wr_q   <= pend_q;
            pend_q <= 1'b0;
        end
    end

    // row payload
    always_ff @(posedge clk) begin
        if (start) begin
            row_q  <= lo_row;
            held_q <= hi_row;
        end else if (pend_q) begin
            row_q  <= held_q;
        end
    end

    assign out_link = '{wr: wr_q, row: row_q};

endmodule

// ==== rtl/row_fifo.sv ====
`timescale 1ns/1ps

module row_fifo import msort_pkg::*; #(
    parameter int DEPTH_LOG2 = 1
) (
    input  logic  clk,
    input  logic  arst_n,
    input  link_t wr_link,
    input  logic  rd,
    output logic  empty,
    output row_t  head
);

    typedef logic [DEPTH_LOG2-1:0] ptr_t;
    // one bit wider than the pointers so a full buffer can be counted
    typedef logic [DEPTH_LOG2:0]   cnt_t;

    row_t mem [2**DEPTH_LOG2];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    // storage
    always_ff @(posedge clk) begin
        if (wr_link.wr) begin
            mem[wr_ptr] <= wr_link.row;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_link.wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            case ({wr_link.wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first word fall through, head valid while not empty
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

endmodule

// ==== rtl/run_merge.sv ====
`timescale 1ns/1ps

module run_merge import msort_pkg::*; #(
    parameter int RUN_LEN = 2
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  sort_num,
    input  logic  left_empty,
    input  row_t  left_head,
    input  logic  right_empty,
    input  row_t  right_head,
    output logic  left_rd,
    output logic  right_rd,
    output link_t out_link
);

    // counts 0 .. RUN_LEN inclusive
    typedef logic [$clog2(RUN_LEN):0] cnt_t;

    cnt_t left_cnt;
    cnt_t right_cnt;

    logic left_done;
    logic right_done;
    logic left_le;
    logic take_left;
    logic take_right;
    logic last_take;

    logic wr_q;
    row_t row_q;

    ////////////////////////////////////////////////////////////////////////////
    // selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // side has given its whole run
        left_done  = (left_cnt == cnt_t'(RUN_LEN));
        right_done = (right_cnt == cnt_t'(RUN_LEN));

        // equal keys go left, keeps the merge stable
        left_le = row_key(left_head, sort_num) <= row_key(right_head, sort_num);

        // while both runs are open both heads are needed for the compare
        take_left  = !left_done && !left_empty &&
                     (right_done || (!right_empty && left_le));
        take_right = !right_done && !right_empty &&
                     (left_done || (!left_empty && !left_le));

        // row 2*RUN_LEN of the merged run
        last_take = (take_left && right_done && left_cnt == cnt_t'(RUN_LEN - 1)) ||
                    (take_right && left_done && right_cnt == cnt_t'(RUN_LEN - 1));
    end

    // pop in the same cycle the row is taken
    assign left_rd  = take_left;
    assign right_rd = take_right;

    ////////////////////////////////////////////////////////////////////////////
    // run counters and output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            left_cnt  <= '0;
            right_cnt <= '0;
            wr_q      <= 1'b0;
        end else begin
            wr_q <= take_left || take_right;
            // back to idle for the next pair of runs
            if (last_take) begin
                left_cnt  <= '0;
                right_cnt <= '0;
            end else if (take_left) begin
                left_cnt  <= left_cnt + 1'b1;
            end else if (take_right) begin
                right_cnt <= right_cnt + 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take_left) begin
            row_q <= left_head;
        end else if (take_right) begin
            row_q <= right_head;
        end
    end

    assign out_link = '{wr: wr_q, row: row_q};

endmodule

// ==== rtl/sort_collect.sv ====
`timescale 1ns/1ps

module sort_collect import msort_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   fifo_empty,
    input  row_t   fifo_head,
    output logic   fifo_rd,
    output frame_t data_out,
    output logic   sorted
);

    logic [ROW_IDX_W-1:0] row_idx;
    logic                 last_row;
    logic                 sorted_q;

    // drain whenever anything is there
    assign fifo_rd  = !fifo_empty;
    assign last_row = (row_idx == ROW_IDX_W'(ROWS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // output table
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
            row_idx  <= '0;
            sorted_q <= 1'b0;
        end else begin
            // one pulse after the write of the last row
            sorted_q <= fifo_rd && last_row;
            if (fifo_rd) begin
                data_out[row_idx] <= fifo_head;
                // wrap for the next frame
                if (last_row) begin
                    row_idx <= '0;
                end else begin
                    row_idx <= row_idx + 1'b1;
                end
            end
        end
    end

    // rows stay in data_out until the next frame overwrites them
    assign sorted = sorted_q;

endmodule

// ==== test/msort_checker.sv ====
`timescale 1ns/1ps

module msort_checker import msort_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  logic   sort_num,
    input  frame_t data_in,
    input  frame_t data_out,
    input  logic   sorted,
    input  logic   run_done,
    output int     errors,
    output int     checked,
    output int     starts,
    output int     pulses
);

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // key column 0 or 1, picked by the sort_num level
    function automatic logic [ELEM_W-1:0] column_key(row_t r, logic sel);
        logic [ELEM_W-1:0] k;
        k = sel ? r[1] : r[0];
        return k;
    endfunction

    // insertion sort, only a strictly greater key moves, so ties keep input order
    function automatic frame_t stable_sort(frame_t f, logic sel);
        row_t   rows [ROWS];
        row_t   tmp;
        int     j;
        frame_t res;
        for (int i = 0; i < ROWS; i++) begin
            rows[i] = f[i];
        end
        for (int i = 1; i < ROWS; i++) begin
            tmp = rows[i];
            j   = i;
            while (j > 0 && column_key(rows[j-1], sel) > column_key(tmp, sel)) begin
                rows[j] = rows[j-1];
                j--;
            end
            rows[j] = tmp;
        end
        for (int i = 0; i < ROWS; i++) begin
            res[i] = rows[i];
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////////////////////

    // one expected frame per start, oldest first
    frame_t expected_q [$];
    frame_t exp_frame;
    frame_t zero_frame  = '0;
    logic   seen_start  = 1'b0;
    logic   end_checked = 1'b0;
    int     err_cnt     = 0;
    int     check_cnt   = 0;
    int     start_cnt   = 0;
    int     pulse_cnt   = 0;

    always @(posedge clk) begin
        if (arst_n) begin
            // idle after reset, nothing may come out yet
            if (!seen_start) begin
                if (sorted) begin
                    $display("sorted pulse seen before any start at %0t", $time);
                    err_cnt++;
                end
                if (data_out !== zero_frame) begin
                    $display("[FAIL] data_out after reset: expected %h actual %h",
                             zero_frame, data_out);
                    err_cnt++;
                end
            end
            // capture the frame on the start cycle
            if (start) begin
                seen_start = 1'b1;
                start_cnt++;
                expected_q.push_back(stable_sort(data_in, sort_num));
            end
            // compare the whole table on the pulse
            if (sorted && seen_start) begin
                pulse_cnt++;
                if (expected_q.size() == 0) begin
                    $display("sorted pulse with no frame outstanding at %0t", $time);
                    err_cnt++;
                end else begin
                    exp_frame = expected_q.pop_front();
                    for (int r = 0; r < ROWS; r++) begin
                        if (data_out[r] !== exp_frame[r]) begin
                            $display("[FAIL] frame %0d row %0d data_out[%0d]: expected %h actual %h",
                                     check_cnt, r, r, exp_frame[r], data_out[r]);
                            err_cnt++;
                        end
                    end
                    check_cnt++;
                end
            end
            // one pulse per start over the whole run
            if (run_done && !end_checked) begin
                end_checked = 1'b1;
                if (pulse_cnt != start_cnt) begin
                    $display("%0d sorted pulses do not match %0d starts", pulse_cnt, start_cnt);
                    err_cnt++;
                end
            end
        end
    end

    assign errors  = err_cnt;
    assign checked = check_cnt;
    assign starts  = start_cnt;
    assign pulses  = pulse_cnt;

endmodule

// ==== test/msort_tb.sv ====
`timescale 1ns/1ps

module msort_tb import msort_pkg::*; #(
    parameter int unsigned SEED = 32'hdf3f1908
);

    localparam int FRAMES           = 200;
    localparam int CLK_PERIOD       = 100;
    localparam int CYCLES_PER_FRAME = 100;
    // whole run budget in ns
    localparam int WATCHDOG_NS      = FRAMES * CYCLES_PER_FRAME * CLK_PERIOD;

    logic   clk;
    logic   arst_n;
    logic   start;
    logic   sort_num;
    frame_t data_in;
    frame_t data_out;
    logic   sorted;
    logic   run_done;
    int     errors;
    int     checked;
    int     starts;
    int     pulses;

    msort_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .sort_num (sort_num),
        .data_in  (data_in),
        .data_out (data_out),
        .sorted   (sorted)
    );

    msort_checker chk0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .sort_num (sort_num),
        .data_in  (data_in),
        .data_out (data_out),
        .sorted   (sorted),
        .run_done (run_done),
        .errors   (errors),
        .checked  (checked),
        .starts   (starts),
        .pulses   (pulses)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // kind 0 random, 1 keys from 0..3, 2 ascending, 3 descending, 4 all equal
    function automatic frame_t make_frame(int kind, logic sel);
        frame_t            f;
        logic [ELEM_W-1:0] base;
        int                key_col;
        key_col = sel ? 1 : 0;
        base    = ELEM_W'($urandom_range(0, 100));
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLUMNS; c++) begin
                f[r][c] = ELEM_W'($urandom());
            end
            case (kind)
                1:       f[r][key_col] = ELEM_W'($urandom_range(0, 3));
                2:       f[r][key_col] = ELEM_W'(base + r * 16);
                3:       f[r][key_col] = ELEM_W'(base + (ROWS - 1 - r) * 16);
                4:       f[r][key_col] = base;
                default: ;
            endcase
        end
        return f;
    endfunction

    // sorted is sampled at the edge, so the next start lands the cycle after it
    task automatic wait_for_sorted();
        do begin
            @(posedge clk);
        end while (!sorted);
    endtask

    initial begin
        int   kind;
        int   gap;
        logic sel;
        void'($urandom(SEED));
        arst_n   = 1'b0;
        start    = 1'b0;
        sort_num = 1'b0;
        data_in  = '0;
        run_done = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        // idle cycles with a quiet output
        repeat (4) @(posedge clk);

        for (int n = 0; n < FRAMES; n++) begin
            kind = $urandom_range(0, 4);
            sel  = 1'($urandom_range(0, 1));
            start    <= 1'b1;
            sort_num <= sel;
            data_in  <= make_frame(kind, sel);
            @(posedge clk);
            start   <= 1'b0;
            // junk rows the DUT must ignore outside the start cycle
            data_in <= make_frame(0, sel);
            wait_for_sorted();
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge clk);
        end

        // room for a stray pulse to show up
        repeat (20) @(posedge clk);
        run_done <= 1'b1;
        repeat (2) @(posedge clk);

        $display("errors %0d, frames checked %0d of %0d, starts %0d, sorted pulses %0d",
                 errors, checked, FRAMES, starts, pulses);
        if (checked != FRAMES) begin
            $display("only %0d of %0d frames were checked", checked, FRAMES);
        end
        if (errors == 0 && checked == FRAMES) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule
